/* logic/fir_pkg.sv */
// Shared definitions for the two-channel audio FIR subsystem.
// Widths of samples, coefficients and results, and the channel codes.

package fir_pkg;

    // Channel layout of a frame.
    localparam int CH_NUM   = 2;
    localparam int CH_LEFT  = 0;
    localparam int CH_RIGHT = 1;

    localparam int DATA_WIDTH = 16;  // Signed input samples.
    localparam int COEF_WIDTH = 18;  // Signed tap coefficients.
    localparam int OUT_WIDTH  = 16;  // Signed scaled results.

endpackage

/* logic/fir_sample_framer.sv */
// Sample framer.
// Pairs each left sample strobe with the right strobe that follows it
// and emits both channels as one frame. Unpaired strobes set a sticky
// framing error flag.

`timescale 1ns/1ps

module fir_sample_framer (
    input  logic                                                  clk_i,
    input  logic                                                  rstn_i,
    input  logic                                                  sample_valid_i,
    input  logic                                                  sample_chan_i,
    input  logic [fir_pkg::DATA_WIDTH-1:0]                        sample_data_i,
    output logic                                                  frame_valid_o,
    output logic [fir_pkg::CH_NUM-1:0][fir_pkg::DATA_WIDTH-1:0]   frame_data_o,
    output logic                                                  framing_err_o
);

    logic                           armed;   // Left sample waiting for its right.
    logic [fir_pkg::DATA_WIDTH-1:0] left_q;
    logic                           is_left;
    logic                           pair_ok;

    assign is_left = (sample_chan_i == 1'(fir_pkg::CH_LEFT));
    assign pair_ok = sample_valid_i && !is_left && armed;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            armed         <= 1'b0;
            frame_valid_o <= 1'b0;
            framing_err_o <= 1'b0;
        end else begin
            frame_valid_o <= pair_ok;
            if (sample_valid_i) begin
                if (is_left) begin
                    armed <= 1'b1;
                    if (armed) begin
                        framing_err_o <= 1'b1;  // Left overwritten before pairing.
                    end
                end else if (armed) begin
                    armed <= 1'b0;
                end else begin
                    framing_err_o <= 1'b1;  // Orphan right sample, dropped.
                end
            end
        end
    end

    // Sample storage and frame assembly.
    always_ff @(posedge clk_i) begin
        if (sample_valid_i && is_left) begin
            left_q <= sample_data_i;
        end
        if (pair_ok) begin
            frame_data_o[fir_pkg::CH_LEFT]  <= left_q;
            frame_data_o[fir_pkg::CH_RIGHT] <= sample_data_i;
        end
    end

    // A frame only ever comes out of an armed pair.
    a_frame_needs_armed : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        frame_valid_o |-> $past(armed)
    ) else $error("frame_valid_o without a pending left sample");

endmodule

/* logic/fir_coef_bank.sv */
// Coefficient bank.
// One register per filter tap, loaded through a strobe write port
// and presented to the multipliers all at once.

`timescale 1ns/1ps

module fir_coef_bank #(
    parameter int TAP_NUM = 16
) (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  logic                                       coef_we_i,
    input  logic [$clog2(TAP_NUM)-1:0]                 coef_addr_i,
    input  logic [fir_pkg::COEF_WIDTH-1:0]             coef_data_i,
    output logic [TAP_NUM-1:0][fir_pkg::COEF_WIDTH-1:0] coefs_o
);

    // Write takes effect on coefs_o the cycle after the strobe.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            coefs_o <= '0;  // Filter passes silence until loaded.
        end else if (coef_we_i) begin
            coefs_o[coef_addr_i] <= coef_data_i;
        end
    end

    a_addr_in_range : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        coef_we_i |-> (coef_addr_i < TAP_NUM)
    ) else $error("coefficient write to tap %0d beyond TAP_NUM", coef_addr_i);

endmodule

/* logic/fir_filter.sv */
// Multichannel pipelined FIR filter.
// Each channel has its own delay line, advanced once per frame, a
// registered multiply per tap and a registered binary adder tree.
// All channels share the coefficient set from the bank.

`timescale 1ns/1ps

module fir_filter #(
    parameter int TAP_NUM   = 16,
    parameter int ACC_WIDTH = 38
) (
    input  logic                                                clk_i,
    input  logic                                                rstn_i,
    input  logic                                                en_i,
    input  logic                                                tvalid_i,
    input  logic [fir_pkg::CH_NUM-1:0][fir_pkg::DATA_WIDTH-1:0] tdata_i,
    input  logic [TAP_NUM-1:0][fir_pkg::COEF_WIDTH-1:0]         coefs_i,
    output logic                                                tvalid_o,
    output logic [fir_pkg::CH_NUM-1:0][ACC_WIDTH-1:0]           tdata_o
);

    localparam int LEVELS     = $clog2(TAP_NUM);
    localparam int PROD_WIDTH = fir_pkg::DATA_WIDTH + fir_pkg::COEF_WIDTH;
    localparam int DELAY      = LEVELS + 2;  // Delay line, multiply, tree levels.
    localparam int LATENCY    = DELAY + 1;   // Plus the output register.

    if (TAP_NUM < 2 || (TAP_NUM & (TAP_NUM - 1)) != 0) begin : g_tap_num_err
        $error("fir_filter: TAP_NUM must be a power of two, at least 2");
    end

    if (ACC_WIDTH < PROD_WIDTH + LEVELS) begin : g_acc_width_err
        $error("fir_filter: ACC_WIDTH too narrow for the adder tree");
    end

    logic [DELAY-1:0] vld_d;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            vld_d    <= '0;
            tvalid_o <= 1'b0;
        end else begin
            vld_d    <= {vld_d[DELAY-2:0], tvalid_i};
            tvalid_o <= vld_d[DELAY-1] && en_i;  // Data still flows when disabled.
        end
    end

    for (genvar ch = 0; ch < fir_pkg::CH_NUM; ch++) begin : g_ch
        logic signed [fir_pkg::DATA_WIDTH-1:0] delay [TAP_NUM];
        logic signed [PROD_WIDTH-1:0]          mult  [TAP_NUM];
        // Heap-ordered tree, node n sums nodes 2n and 2n+1, root at 1.
        logic signed [ACC_WIDTH-1:0]           node  [1:TAP_NUM-1];

        // Newest sample sits at tap 0.
        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                for (int t = 0; t < TAP_NUM; t++) begin
                    delay[t] <= '0;
                end
            end else if (tvalid_i) begin
                delay[0] <= $signed(tdata_i[ch]);
                for (int t = 1; t < TAP_NUM; t++) begin
                    delay[t] <= delay[t-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            for (int t = 0; t < TAP_NUM; t++) begin
                mult[t] <= delay[t] * $signed(coefs_i[t]);
            end
        end

        // First level takes product pairs, upper levels take node pairs.
        always_ff @(posedge clk_i) begin
            for (int n = TAP_NUM / 2; n < TAP_NUM; n++) begin
                node[n] <= ACC_WIDTH'(mult[2*n-TAP_NUM]) + ACC_WIDTH'(mult[2*n-TAP_NUM+1]);
            end
            for (int n = 1; n < TAP_NUM / 2; n++) begin
                node[n] <= node[2*n] + node[2*n+1];
            end
        end

        always_ff @(posedge clk_i) begin
            tdata_o[ch] <= node[1];
        end
    end

    // Output strobe lines up with the data it belongs to.
    a_valid_latency : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        tvalid_o == ($past(tvalid_i, LATENCY) && $past(en_i))
    ) else $error("tvalid_o out of step with the %0d-cycle pipeline", LATENCY);

endmodule

/* logic/fir_output_scaler.sv */
// Output scaler.
// Rounds each channel's wide filter result, shifts it down by OUT_SHIFT
// and saturates it to the output width. Flags clipped channels.

`timescale 1ns/1ps

module fir_output_scaler #(
    parameter int ACC_WIDTH = 38,
    parameter int OUT_SHIFT = 17
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,
    input  logic                                               acc_valid_i,
    input  logic [fir_pkg::CH_NUM-1:0][ACC_WIDTH-1:0]          acc_data_i,
    output logic                                               out_valid_o,
    output logic [fir_pkg::CH_NUM-1:0][fir_pkg::OUT_WIDTH-1:0] out_data_o,
    output logic [fir_pkg::CH_NUM-1:0]                         clip_o
);

    localparam int SUM_WIDTH = ACC_WIDTH + 1;  // Room for the rounding carry.
    localparam int SHR_WIDTH = SUM_WIDTH - OUT_SHIFT;
    localparam int PAD_WIDTH = SHR_WIDTH - fir_pkg::OUT_WIDTH + 1;

    localparam logic signed [SUM_WIDTH-1:0] HALF    = SUM_WIDTH'(1) << (OUT_SHIFT - 1);
    localparam logic signed [SHR_WIDTH-1:0] SAT_MAX =
        {{PAD_WIDTH{1'b0}}, {(fir_pkg::OUT_WIDTH - 1){1'b1}}};
    localparam logic signed [SHR_WIDTH-1:0] SAT_MIN =
        {{PAD_WIDTH{1'b1}}, {(fir_pkg::OUT_WIDTH - 1){1'b0}}};

    if (OUT_SHIFT < 1 || SHR_WIDTH < fir_pkg::OUT_WIDTH) begin : g_shift_err
        $error("fir_output_scaler: OUT_SHIFT out of range for ACC_WIDTH");
    end

    logic [fir_pkg::CH_NUM-1:0][fir_pkg::OUT_WIDTH-1:0] sat_data;
    logic [fir_pkg::CH_NUM-1:0]                         sat_clip;

    for (genvar ch = 0; ch < fir_pkg::CH_NUM; ch++) begin : g_ch
        logic signed [SUM_WIDTH-1:0] rnd;
        logic signed [SHR_WIDTH-1:0] shr;
        logic                        over;
        logic                        under;

        assign rnd   = SUM_WIDTH'($signed(acc_data_i[ch])) + HALF;  // Round half up.
        assign shr   = SHR_WIDTH'(rnd >>> OUT_SHIFT);
        assign over  = (shr > SAT_MAX);
        assign under = (shr < SAT_MIN);

        assign sat_data[ch] = over  ? SAT_MAX[fir_pkg::OUT_WIDTH-1:0] :
                              under ? SAT_MIN[fir_pkg::OUT_WIDTH-1:0] :
                                      shr[fir_pkg::OUT_WIDTH-1:0];
        assign sat_clip[ch] = over || under;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
            clip_o      <= '0;
        end else begin
            out_valid_o <= acc_valid_i;
            clip_o      <= acc_valid_i ? sat_clip : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (acc_valid_i) begin
            out_data_o <= sat_data;
        end
    end

    a_clip_only_valid : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !out_valid_o |-> (clip_o == '0)
    ) else $error("clip_o set without out_valid_o");

endmodule

/* logic/fir_subsystem_top.sv */
// Two-channel audio FIR subsystem.
// Framer, run-time loaded coefficient bank, shared-coefficient FIR
// filter and output scaler. Right sample strobe to result is 9 cycles
// with the default 16 taps.

`timescale 1ns/1ps

module fir_subsystem_top #(
    parameter int TAP_NUM   = 16,
    parameter int OUT_SHIFT = 17
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,
    input  logic                                               enable_i,
    input  logic                                               sample_valid_i,
    input  logic                                               sample_chan_i,
    input  logic [fir_pkg::DATA_WIDTH-1:0]                     sample_data_i,
    input  logic                                               coef_we_i,
    input  logic [$clog2(TAP_NUM)-1:0]                         coef_addr_i,
    input  logic [fir_pkg::COEF_WIDTH-1:0]                     coef_data_i,
    output logic                                               out_valid_o,
    output logic [fir_pkg::CH_NUM-1:0][fir_pkg::OUT_WIDTH-1:0] out_data_o,
    output logic [fir_pkg::CH_NUM-1:0]                         clip_o,
    output logic                                               framing_err_o
);

    // Full-precision sum of TAP_NUM products.
    localparam int ACC_WIDTH = fir_pkg::DATA_WIDTH + fir_pkg::COEF_WIDTH + $clog2(TAP_NUM);

    logic                                                frame_valid;
    logic [fir_pkg::CH_NUM-1:0][fir_pkg::DATA_WIDTH-1:0] frame_data;
    logic [TAP_NUM-1:0][fir_pkg::COEF_WIDTH-1:0]         coefs;
    logic                                                acc_valid;
    logic [fir_pkg::CH_NUM-1:0][ACC_WIDTH-1:0]           acc_data;

    fir_sample_framer i_framer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .sample_valid_i (sample_valid_i),
        .sample_chan_i  (sample_chan_i),
        .sample_data_i  (sample_data_i),
        .frame_valid_o  (frame_valid),
        .frame_data_o   (frame_data),
        .framing_err_o  (framing_err_o)
    );

    fir_coef_bank #(
        .TAP_NUM (TAP_NUM)
    ) i_coef_bank (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .coef_we_i   (coef_we_i),
        .coef_addr_i (coef_addr_i),
        .coef_data_i (coef_data_i),
        .coefs_o     (coefs)
    );

    fir_filter #(
        .TAP_NUM   (TAP_NUM),
        .ACC_WIDTH (ACC_WIDTH)
    ) i_filter (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .en_i     (enable_i),
        .tvalid_i (frame_valid),
        .tdata_i  (frame_data),
        .coefs_i  (coefs),
        .tvalid_o (acc_valid),
        .tdata_o  (acc_data)
    );

    fir_output_scaler #(
        .ACC_WIDTH (ACC_WIDTH),
        .OUT_SHIFT (OUT_SHIFT)
    ) i_scaler (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .acc_valid_i (acc_valid),
        .acc_data_i  (acc_data),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .clip_o      (clip_o)
    );

endmodule

/* bench/fir_tb.sv */
// Testbench for the two-channel audio FIR subsystem.
// Replays coefficient writes, samples and expected results from the
// golden file, and checks every output frame in order.

`timescale 1ns/1ps

module fir_tb;

    localparam int TAP_NUM      = 16;
    localparam int DRAIN_CYCLES = 12;   // Longer than the 9-cycle latency.
    localparam int WAIT_LIMIT   = 200;

    logic                                               clk_i;
    logic                                               rstn_i;
    logic                                               enable_i;
    logic                                               sample_valid_i;
    logic                                               sample_chan_i;
    logic [fir_pkg::DATA_WIDTH-1:0]                     sample_data_i;
    logic                                               coef_we_i;
    logic [$clog2(TAP_NUM)-1:0]                         coef_addr_i;
    logic [fir_pkg::COEF_WIDTH-1:0]                     coef_data_i;
    logic                                               out_valid_o;
    logic [fir_pkg::CH_NUM-1:0][fir_pkg::OUT_WIDTH-1:0] out_data_o;
    logic [fir_pkg::CH_NUM-1:0]                         clip_o;
    logic                                               framing_err_o;

    int         exp_left_q[$];
    int         exp_right_q[$];
    logic [1:0] exp_clip_q[$];
    int         err_cnt;
    int         out_cnt;
    bit         left_pending;    // Model of the framer's armed state.
    bit         err_expected;    // Sticky framing error as predicted.
    int         mon_left;
    int         mon_right;
    logic [1:0] mon_clip;

    fir_subsystem_top i_dut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .enable_i       (enable_i),
        .sample_valid_i (sample_valid_i),
        .sample_chan_i  (sample_chan_i),
        .sample_data_i  (sample_data_i),
        .coef_we_i      (coef_we_i),
        .coef_addr_i    (coef_addr_i),
        .coef_data_i    (coef_data_i),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .clip_o         (clip_o),
        .framing_err_o  (framing_err_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Outputs settle after the rising edge, compare on the falling one.
    always @(negedge clk_i) begin
        if (rstn_i && out_valid_o) begin
            out_cnt++;
            if (exp_left_q.size() == 0) begin
                $display("Output frame at %0t arrived with no result expected", $time);
                err_cnt++;
            end else begin
                mon_left  = exp_left_q.pop_front();
                mon_right = exp_right_q.pop_front();
                mon_clip  = exp_clip_q.pop_front();
                if (int'($signed(out_data_o[fir_pkg::CH_LEFT])) != mon_left) begin
                    $display("ERR t=%0t out_data_o[left] expected %0d got %0d", $time,
                             mon_left, $signed(out_data_o[fir_pkg::CH_LEFT]));
                    err_cnt++;
                end
                if (int'($signed(out_data_o[fir_pkg::CH_RIGHT])) != mon_right) begin
                    $display("ERR t=%0t out_data_o[right] expected %0d got %0d", $time,
                             mon_right, $signed(out_data_o[fir_pkg::CH_RIGHT]));
                    err_cnt++;
                end
                if (clip_o != mon_clip) begin
                    $display("ERR t=%0t clip_o expected %b got %b", $time, mon_clip, clip_o);
                    err_cnt++;
                end
            end
        end
    end

    // Advance to the drive point just after the next rising edge.
    task automatic tick();
        @(posedge clk_i);
        #10;
    endtask

    task automatic write_coef(input int addr, input int value);
        coef_we_i   = 1'b1;
        coef_addr_i = 4'(addr);
        coef_data_i = 18'(value);
        tick();
        coef_we_i = 1'b0;
    endtask

    task automatic send_sample(input int chan, input int value);
        int gap;
        gap = 0;
        if (chan == fir_pkg::CH_LEFT) begin
            if (left_pending) err_expected = 1'b1;
            left_pending = 1'b1;
        end else if (left_pending) begin
            left_pending = 1'b0;
        end else begin
            err_expected = 1'b1;  // Orphan right is dropped.
        end
        sample_valid_i = 1'b1;
        sample_chan_i  = 1'(chan);
        sample_data_i  = 16'(value);
        tick();
        sample_valid_i = 1'b0;
        if (chan == fir_pkg::CH_RIGHT) begin
            gap = int'($urandom % 4);
            repeat (gap) tick();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_left_q.size() != 0 && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (exp_left_q.size() != 0) begin
            $display("Timeout: %0d expected output frames never arrived", exp_left_q.size());
            err_cnt++;
        end
        repeat (DRAIN_CYCLES) tick();
        if (framing_err_o != err_expected) begin
            $display("ERR t=%0t framing_err_o expected %b got %b", $time,
                     err_expected, framing_err_o);
            err_cnt++;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    a;
        int    b;
        int    c;
        int    d;
        string line;
        byte   tag;

        err_cnt        = 0;
        out_cnt        = 0;
        left_pending   = 1'b0;
        err_expected   = 1'b0;
        rstn_i         = 1'b0;
        enable_i       = 1'b1;
        sample_valid_i = 1'b0;
        sample_chan_i  = 1'b0;
        sample_data_i  = '0;
        coef_we_i      = 1'b0;
        coef_addr_i    = '0;
        coef_data_i    = '0;
        void'($urandom(17161));

        repeat (4) @(posedge clk_i);
        #10;
        rstn_i = 1'b1;
        tick();

        fd = $fopen("bench/fir_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file bench/fir_golden.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 1) begin
                    tag = line.getc(0);
                    a = 0;
                    b = 0;
                    c = 0;
                    d = 0;
                    code = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", a, b, c, d);
                    case (tag)
                        "C": write_coef(a, b);
                        "S": send_sample(a, b);
                        "E": begin
                            exp_left_q.push_back(a);
                            exp_right_q.push_back(b);
                            exp_clip_q.push_back({1'(d), 1'(c)});
                        end
                        "N": begin
                            enable_i = 1'(a);
                            tick();
                        end
                        "W": drain();
                        "#": ;
                        default: begin
                            $display("Unknown tag in golden file line: %s", line);
                            err_cnt++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        drain();
        $display("Checked %0d output frames, %0d errors", out_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/fir_golden.txt */
# C addr coef | S chan sample | E left right clip_left clip_right
# N enable | W drain pipeline; chan 0 is left, 1 is right
C 0 80
C 1 -160
C 2 240
C 3 -320
C 4 400
C 5 -480
C 6 560
C 7 -640
S 0 16384
S 1 0
E 10 0 0 0
S 0 0
S 1 0
E -20 0 0 0
S 0 0
S 1 0
E 30 0 0 0
S 0 0
S 1 0
E -40 0 0 0
S 0 0
S 1 0
E 50 0 0 0
S 0 0
S 1 0
E -60 0 0 0
S 0 0
S 1 0
E 70 0 0 0
S 0 0
S 1 0
E -80 0 0 0
W
# Two-tap average, taps 0 and 1 at 65536.
C 0 65536
C 1 65536
C 2 0
C 3 0
C 4 0
C 5 0
C 6 0
C 7 0
S 0 1000
S 1 -500
E 500 -250 0 0
S 0 3001
S 1 -7
E 2001 -253 0 0
S 0 -1234
S 1 20000
E 884 9997 0 0
S 0 32767
S 1 -32768
E 15767 -6384 0 0
S 0 12345
S 1 -12345
E 22556 -22556 0 0
S 0 -3
S 1 2
E 6171 -6171 0 0
S 0 0
S 1 1
E -1 2 0 0
W
N 0
S 0 100
S 1 200
S 0 300
S 1 400
W
N 1
S 0 -100
S 1 50
E 100 225 0 0
S 1 5
S 0 7
S 1 -9
E -46 21 0 0
W
# Reload, add tap 2 so three taps sum and can saturate.
C 2 65536
S 0 32767
S 1 -32768
E 16337 -16363 0 0
S 0 32767
S 1 -32768
E 32767 -32768 1 1
S 0 32767
S 1 0
E 32767 -32768 1 0
S 0 -20000
S 1 1000
E 22767 -15884 0 0
W

/* fir_subsystem.f */
logic/fir_pkg.sv
logic/fir_sample_framer.sv
logic/fir_coef_bank.sv
logic/fir_filter.sv
logic/fir_output_scaler.sv
logic/fir_subsystem_top.sv
bench/fir_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FIR subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fir_subsystem.f \
    --top-module fir_tb \
    -Mdir obj_dir

sim_out=$(./obj_dir/Vfir_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
